// ==== src/pad_link_pkg.sv ====
// frame geometry of the pad link; the header sits in the top bits of a frame and slip positions stop at FRAME_W-1
package pad_link_pkg;

    // line word and frame sizes
    localparam int WORD_W          = 20;
    localparam int WORDS_PER_FRAME = 6;
    localparam int FRAME_W         = WORD_W * WORDS_PER_FRAME;  // 120 bits

    // sync header, first bits on the line
    localparam int HEADER_W = 4;
    localparam logic [HEADER_W-1:0] SYNC_HEADER = 4'b1010;

    // payload below the header
    localparam int PAYLOAD_W = FRAME_W - HEADER_W;  // 116 bits
    localparam int BCID_W    = 12;                  // top payload bits
    localparam int HIT_W     = PAYLOAD_W - BCID_W;  // 104 bits of hit data

    // status counter
    localparam int DROP_W = 16;

    // word index inside a frame, 0 to 5
    typedef logic [2:0] slot_t;

    // bit offset of the frame boundary, 0 to 119
    typedef logic [6:0] slip_t;

endpackage

// ==== src/frame_gather.sv ====
// frame slots follow reset release; the first word sampled after reset starts slot 0 and bit 19 is the oldest line bit
`timescale 1ns/1ps

module frame_gather (
    input  logic                                USER_CLK,
    input  logic                                system_reset_r2,
    input  logic [pad_link_pkg::WORD_W-1:0]     line_word,
    output logic                                frame_strobe,
    output logic [pad_link_pkg::FRAME_W-1:0]    frame_new,
    output logic [pad_link_pkg::FRAME_W-1:0]    frame_old,
    output logic                                word_hist_equal
);
    import pad_link_pkg::*;

    localparam slot_t LAST_SLOT = slot_t'(WORDS_PER_FRAME - 1);

    // word_q[0] is the newest word and the oldest ends up in the frame msbs
    logic [WORDS_PER_FRAME-1:0][WORD_W-1:0] word_q;
    slot_t                                  slot;
    logic                                   chain_full;  // six fresh words in word_q

    // slot counter and strobes
    always_ff @(posedge USER_CLK) begin
        if (system_reset_r2) begin
            slot         <= '0;
            chain_full   <= 1'b0;
            frame_strobe <= 1'b0;
        end else begin
            slot         <= (slot == LAST_SLOT) ? '0 : slot + slot_t'(1);
            chain_full   <= (slot == LAST_SLOT);
            frame_strobe <= chain_full;  // frame_new is valid with this pulse
        end
    end

    // word chain shifts every cycle as the line never stalls
    always_ff @(posedge USER_CLK) begin
        word_q <= {word_q[WORDS_PER_FRAME-2:0], line_word};
    end

    // keep two frames so the aligner can look across the boundary
    always_ff @(posedge USER_CLK) begin
        if (chain_full) begin
            frame_new <= word_q;
            frame_old <= frame_new;
        end
    end

    // a stuck line repeats the same word
    always_comb begin
        word_hist_equal = 1'b1;
        for (int i = 1; i < 5; i++) begin
            if (word_q[i] != word_q[0]) begin
                word_hist_equal = 1'b0;
            end
        end
    end

    a_slot_range : assert property (@(posedge USER_CLK) disable iff (system_reset_r2)
        slot <= LAST_SLOT);

endmodule

// ==== src/frame_aligner.sv ====
// one cycle of latency; slip_pos counts bits from the first bit of frame_old and must stay below FRAME_W
`timescale 1ns/1ps

module frame_aligner (
    input  logic                                USER_CLK,
    input  logic                                system_reset_r2,
    input  logic                                frame_strobe,
    input  logic [pad_link_pkg::FRAME_W-1:0]    frame_new,
    input  logic [pad_link_pkg::FRAME_W-1:0]    frame_old,
    input  pad_link_pkg::slip_t                 slip_pos,
    output logic                                aligned_strobe,
    output logic [pad_link_pkg::FRAME_W-1:0]    aligned_frame
);
    import pad_link_pkg::*;

    localparam int SHIFT_W = $clog2(2 * FRAME_W);

    logic [2*FRAME_W-1:0] bit_seq;      // oldest bit in the msb
    logic [FRAME_W-1:0]   bit_seq_shr;
    logic [SHIFT_W-1:0]   shift_amt;

    // window starts slip_pos bits into frame_old so drop FRAME_W - slip_pos bits below it
    always_comb begin
        bit_seq     = {frame_old, frame_new};
        shift_amt   = SHIFT_W'(FRAME_W) - SHIFT_W'(slip_pos);
        bit_seq_shr = FRAME_W'(bit_seq >> shift_amt);
    end

    always_ff @(posedge USER_CLK) begin
        if (system_reset_r2) begin
            aligned_strobe <= 1'b0;
        end else begin
            aligned_strobe <= frame_strobe;
        end
    end

    always_ff @(posedge USER_CLK) begin
        if (frame_strobe) begin
            aligned_frame <= bit_seq_shr;
        end
    end

    a_slip_range : assert property (@(posedge USER_CLK) disable iff (system_reset_r2)
        frame_strobe |-> slip_pos < FRAME_W);

endmodule

// ==== src/link_lock_fsm.sv ====
// lock needs SYNC_FRAMES good headers with fewer than 3 bad; in lock bad headers never decay until LOSS_ERRORS
`timescale 1ns/1ps

module link_lock_fsm #(
    parameter int SYNC_FRAMES = 16,
    parameter int HUNT_ERRORS = 5,
    parameter int LOSS_ERRORS = 16
) (
    input  logic                                USER_CLK,
    input  logic                                system_reset_r2,
    input  logic                                aligned_strobe,
    input  logic [pad_link_pkg::HEADER_W-1:0]   aligned_header,
    output logic                                locked,
    output pad_link_pkg::slip_t                 slip_pos
);
    import pad_link_pkg::*;

    localparam int GOOD_W  = $clog2(SYNC_FRAMES + 1);
    localparam int BAD_MAX = (HUNT_ERRORS + 1 > LOSS_ERRORS) ? HUNT_ERRORS + 1 : LOSS_ERRORS;
    localparam int BAD_W   = $clog2(BAD_MAX + 1);
    localparam int LOCK_BAD_LIMIT = 3;  // bad headers tolerated while building lock
    localparam slip_t LAST_SLIP   = slip_t'(FRAME_W - 1);

    typedef enum logic {
        ST_HUNT,
        ST_LOCKED
    } state_t;

    state_t            state;
    logic [GOOD_W-1:0] good_cnt;
    logic [BAD_W-1:0]  bad_cnt;
    logic              header_ok;
    logic [GOOD_W-1:0] good_inc;
    logic [BAD_W-1:0]  bad_inc;

    // counts including the frame at hand
    always_comb begin
        header_ok = (aligned_header == SYNC_HEADER);
        good_inc  = header_ok ? good_cnt + GOOD_W'(1) : good_cnt;
        bad_inc   = header_ok ? bad_cnt : bad_cnt + BAD_W'(1);
    end

    always_ff @(posedge USER_CLK) begin
        if (system_reset_r2) begin
            state    <= ST_HUNT;
            good_cnt <= '0;
            bad_cnt  <= '0;
            slip_pos <= '0;
        end else if (aligned_strobe) begin
            case (state)
                ST_HUNT: begin
                    if (good_inc >= GOOD_W'(SYNC_FRAMES)) begin
                        // full window seen so lock or start a fresh window
                        good_cnt <= '0;
                        bad_cnt  <= '0;
                        if (bad_inc < BAD_W'(LOCK_BAD_LIMIT)) begin
                            state <= ST_LOCKED;
                        end
                    end else if (bad_inc > BAD_W'(HUNT_ERRORS)) begin
                        // wrong boundary so try the next bit
                        good_cnt <= '0;
                        bad_cnt  <= '0;
                        slip_pos <= (slip_pos == LAST_SLIP) ? '0 : slip_pos + slip_t'(1);
                    end else begin
                        good_cnt <= good_inc;
                        bad_cnt  <= bad_inc;
                    end
                end

                ST_LOCKED: begin
                    if (bad_inc >= BAD_W'(LOSS_ERRORS)) begin
                        state    <= ST_HUNT;  // keep slip_pos and rehunt from here
                        good_cnt <= '0;
                        bad_cnt  <= '0;
                    end else begin
                        bad_cnt <= bad_inc;
                    end
                end
            endcase
        end
    end

    assign locked = (state == ST_LOCKED);

endmodule

// ==== src/frame_output.sv ====
// one frame of storage; a frame arriving while the held one stalls is dropped, and the drop count saturates
`timescale 1ns/1ps

module frame_output (
    input  logic                                USER_CLK,
    input  logic                                system_reset_r2,
    input  logic                                aligned_strobe,
    input  logic [pad_link_pkg::PAYLOAD_W-1:0]  aligned_payload,
    input  logic                                locked,
    input  logic                                frame_ready,
    output logic                                frame_valid,
    output logic [pad_link_pkg::BCID_W-1:0]     bcid,
    output logic [pad_link_pkg::HIT_W-1:0]      hit_data,
    output logic                                hit_flag,
    output logic [pad_link_pkg::DROP_W-1:0]     dropped_count
);
    import pad_link_pkg::*;

    logic take_frame;  // new locked frame on this edge
    logic has_room;    // output register empty or emptying now
    logic load_frame;

    always_comb begin
        take_frame = aligned_strobe && locked;
        has_room   = !frame_valid || frame_ready;
        load_frame = take_frame && has_room;
    end

    always_ff @(posedge USER_CLK) begin
        if (system_reset_r2) begin
            frame_valid   <= 1'b0;
            dropped_count <= '0;
        end else begin
            if (load_frame) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end

            if (take_frame && !has_room && dropped_count != '1) begin
                dropped_count <= dropped_count + DROP_W'(1);
            end
        end
    end

    // split fields and flag hits when loading
    always_ff @(posedge USER_CLK) begin
        if (load_frame) begin
            bcid     <= aligned_payload[PAYLOAD_W-1 -: BCID_W];
            hit_data <= aligned_payload[HIT_W-1:0];
            hit_flag <= |aligned_payload[HIT_W-1:0];
        end
    end

    a_hold_stable : assert property (@(posedge USER_CLK) disable iff (system_reset_r2)
        frame_valid && !frame_ready |=>
            frame_valid && $stable(bcid) && $stable(hit_data) && $stable(hit_flag));

endmodule

// ==== src/pad_link_top.sv ====
// disconnected is reported on its own and does not mask locked; lock thresholds come from the parameters
`timescale 1ns/1ps

module pad_link_top #(
    parameter int SYNC_FRAMES = 16,
    parameter int HUNT_ERRORS = 5,
    parameter int LOSS_ERRORS = 16
) (
    input  logic                                USER_CLK,
    input  logic                                system_reset_r2,
    input  logic [pad_link_pkg::WORD_W-1:0]     line_word,
    input  logic                                frame_ready,
    output logic                                frame_valid,
    output logic [pad_link_pkg::BCID_W-1:0]     bcid,
    output logic [pad_link_pkg::HIT_W-1:0]      hit_data,
    output logic                                hit_flag,
    output logic [pad_link_pkg::DROP_W-1:0]     dropped_count,
    output logic                                locked,
    output pad_link_pkg::slip_t                 slip_pos,
    output logic                                disconnected
);
    import pad_link_pkg::*;

    logic                 frame_strobe;
    logic [FRAME_W-1:0]   frame_new;
    logic [FRAME_W-1:0]   frame_old;
    logic                 word_hist_equal;
    logic                 aligned_strobe;
    logic [FRAME_W-1:0]   aligned_frame;
    logic [HEADER_W-1:0]  aligned_header;
    logic [PAYLOAD_W-1:0] aligned_payload;

    assign aligned_header  = aligned_frame[FRAME_W-1 -: HEADER_W];
    assign aligned_payload = aligned_frame[PAYLOAD_W-1:0];

    frame_gather u_gather (
        .USER_CLK        (USER_CLK),
        .system_reset_r2 (system_reset_r2),
        .line_word       (line_word),
        .frame_strobe    (frame_strobe),
        .frame_new       (frame_new),
        .frame_old       (frame_old),
        .word_hist_equal (word_hist_equal)
    );

    frame_aligner u_aligner (
        .USER_CLK        (USER_CLK),
        .system_reset_r2 (system_reset_r2),
        .frame_strobe    (frame_strobe),
        .frame_new       (frame_new),
        .frame_old       (frame_old),
        .slip_pos        (slip_pos),
        .aligned_strobe  (aligned_strobe),
        .aligned_frame   (aligned_frame)
    );

    link_lock_fsm #(
        .SYNC_FRAMES (SYNC_FRAMES),
        .HUNT_ERRORS (HUNT_ERRORS),
        .LOSS_ERRORS (LOSS_ERRORS)
    ) u_lock (
        .USER_CLK        (USER_CLK),
        .system_reset_r2 (system_reset_r2),
        .aligned_strobe  (aligned_strobe),
        .aligned_header  (aligned_header),
        .locked          (locked),
        .slip_pos        (slip_pos)
    );

    frame_output u_output (
        .USER_CLK        (USER_CLK),
        .system_reset_r2 (system_reset_r2),
        .aligned_strobe  (aligned_strobe),
        .aligned_payload (aligned_payload),
        .locked          (locked),
        .frame_ready     (frame_ready),
        .frame_valid     (frame_valid),
        .bcid            (bcid),
        .hit_data        (hit_data),
        .hit_flag        (hit_flag),
        .dropped_count   (dropped_count)
    );

    // stuck line flag, registered once
    always_ff @(posedge USER_CLK) begin
        if (system_reset_r2) begin
            disconnected <= 1'b0;
        end else begin
            disconnected <= word_hist_equal;
        end
    end

endmodule

// ==== testbench/tb_pad_link_model.svh ====
// stimulus model included into the testbench module; frames are built on demand, BCID counts frames from 0
int unsigned       lcg_state = 32'h2649;
bit                stream_q[$];     // line bits, oldest first
logic [BCID_W-1:0] exp_bcid_q[$];   // expected frames in line order
logic [HIT_W-1:0]  exp_hit_q[$];
int                frame_count = 0;
int                corrupt_left = 0;  // headers still to corrupt
logic [BCID_W-1:0] last_bad_bcid = '0;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper half only, the low lcg bits repeat quickly
function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
endfunction

// random bits ahead of the first frame set the bit offset
function automatic void push_filler(input int nbits);
    logic [15:0] r;
    for (int i = 0; i < nbits; i++) begin
        r = rand16();
        stream_q.push_back(r[15]);
    end
endfunction

function automatic void push_frame();
    logic [HEADER_W-1:0] header;
    logic [BCID_W-1:0]   frame_bcid;
    logic [HIT_W-1:0]    hit;
    logic [FRAME_W-1:0]  frame;
    header     = SYNC_HEADER;
    frame_bcid = BCID_W'(frame_count);
    hit        = '0;
    if (frame_count % 4 != 3) begin  // every fourth frame carries no hits
        for (int i = 0; i < 7; i++) begin
            hit = {hit[HIT_W-17:0], rand16()};
        end
    end
    if (corrupt_left > 0) begin
        header        = ~SYNC_HEADER;
        last_bad_bcid = frame_bcid;
        corrupt_left--;
    end
    frame = {header, frame_bcid, hit};
    for (int b = FRAME_W - 1; b >= 0; b--) begin
        stream_q.push_back(frame[b]);  // msb goes out first
    end
    exp_bcid_q.push_back(frame_bcid);
    exp_hit_q.push_back(hit);
    frame_count++;
endfunction

// first bit of the word lands in bit 19
function automatic logic [WORD_W-1:0] next_line_word();
    logic [WORD_W-1:0] w;
    while (stream_q.size() < WORD_W) begin
        push_frame();
    end
    for (int b = WORD_W - 1; b >= 0; b--) begin
        w[b] = stream_q.pop_front();
    end
    return w;
endfunction

// ==== testbench/tb_pad_link.sv ====
// runs below 4096 frames so BCIDs stay unique; stops at the first mismatch or timeout
`timescale 1ns/1ps

module tb_pad_link;
    import pad_link_pkg::*;

    localparam int START_OFFSET  = 133;   // frames start this many bits into the line
    localparam int LOCK_TIMEOUT  = 4000;
    localparam int FRAME_TIMEOUT = 200;
    localparam int LINE_TIMEOUT  = 20;
    localparam logic [WORD_W-1:0] STUCK_WORD = 20'h3C5A1;

    logic              USER_CLK;
    logic              system_reset_r2;
    logic [WORD_W-1:0] line_word;
    logic              frame_ready;
    logic              frame_valid;
    logic [BCID_W-1:0] bcid;
    logic [HIT_W-1:0]  hit_data;
    logic              hit_flag;
    logic [DROP_W-1:0] dropped_count;
    logic              locked;
    slip_t             slip_pos;
    logic              disconnected;

    int   line_mode  = 0;  // 0 frame stream, 1 stuck word, 2 random words
    int   ready_mode = 1;  // 0 low, 1 high, 2 random
    bit   check_output = 1'b1;
    bit   allow_skip   = 1'b0;
    bit   synced       = 1'b0;  // first output frame matched
    int   skip_total   = 0;
    logic held_valid   = 1'b0;
    logic [BCID_W-1:0] held_bcid;
    logic [HIT_W-1:0]  held_hit;
    logic              held_flag;
    logic              accepted_now = 1'b0;
    logic [BCID_W-1:0] accepted_bcid = '0;
    logic [DROP_W-1:0] drop_base;
    int                skip_base;

    `include "tb_pad_link_model.svh"

    pad_link_top uut (
        .USER_CLK        (USER_CLK),
        .system_reset_r2 (system_reset_r2),
        .line_word       (line_word),
        .frame_ready     (frame_ready),
        .frame_valid     (frame_valid),
        .bcid            (bcid),
        .hit_data        (hit_data),
        .hit_flag        (hit_flag),
        .dropped_count   (dropped_count),
        .locked          (locked),
        .slip_pos        (slip_pos),
        .disconnected    (disconnected)
    );

    initial begin
        USER_CLK = 1'b0;
        forever #2 USER_CLK = ~USER_CLK;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_status(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input logic [DROP_W-1:0] got,
                               input logic [DROP_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0d ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_slip(input slip_t got, input slip_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0d ns: slip_pos is %0d, expected %0d", $time, got, exp));
        end
    endtask

    // fields in the message are bcid/hit_data/hit_flag
    task automatic check_frame(input string what,
                               input logic [BCID_W-1:0] got_bcid, input logic [HIT_W-1:0] got_hit,
                               input logic got_flag, input logic [BCID_W-1:0] exp_bcid,
                               input logic [HIT_W-1:0] exp_hit, input logic exp_flag);
        if (got_bcid !== exp_bcid || got_hit !== exp_hit || got_flag !== exp_flag) begin
            abort_run($sformatf("[ERROR] t=%0d ns: %s got %h/%h/%b, expected %h/%h/%b", $time,
                what, got_bcid, got_hit, got_flag, exp_bcid, exp_hit, exp_flag));
        end
    endtask

    task automatic check_reset_state();
        check_status("frame_valid in reset", frame_valid, 1'b0);
        check_status("locked in reset", locked, 1'b0);
        check_slip(slip_pos, '0);
        check_count("dropped_count in reset", dropped_count, '0);
    endtask

    task automatic drive_inputs();
        logic [15:0] r;
        case (line_mode)
            0: line_word = next_line_word();
            1: line_word = STUCK_WORD;
            default: line_word = WORD_W'({rand16(), rand16()});
        endcase
        case (ready_mode)
            0: frame_ready = 1'b0;
            1: frame_ready = 1'b1;
            default: begin
                r = rand16();
                frame_ready = (r[2:0] == 3'd0);  // mostly stalled, so frames get dropped
            end
        endcase
    endtask

    // accepted frame must be a later queued frame, earlier ones count as skipped
    task automatic match_expected();
        int               skipped;
        logic [BCID_W-1:0] exp_bcid;
        logic [HIT_W-1:0]  exp_hit;
        skipped = 0;
        while (exp_bcid_q.size() > 0 && exp_bcid_q[0] != bcid) begin
            void'(exp_bcid_q.pop_front());
            void'(exp_hit_q.pop_front());
            skipped++;
        end
        if (exp_bcid_q.size() == 0) begin
            abort_run($sformatf("[ERROR] t=%0d ns: bcid %h is not a later queued frame", $time, bcid));
        end else if (synced && !allow_skip && skipped != 0) begin
            abort_run($sformatf("[ERROR] t=%0d ns: %0d frames missing before bcid %h",
                $time, skipped, bcid));
        end else begin
            if (synced) begin
                skip_total += skipped;
            end
            synced   = 1'b1;
            exp_bcid = exp_bcid_q.pop_front();
            exp_hit  = exp_hit_q.pop_front();
            check_frame("accepted frame", bcid, hit_data, hit_flag, exp_bcid, exp_hit,
                exp_hit != '0);
        end
    endtask

    task automatic observe_output();
        accepted_now = 1'b0;
        if (check_output) begin
            if (held_valid) begin  // stalled last cycle
                check_status("frame_valid while stalled", frame_valid, 1'b1);
                check_frame("stalled output", bcid, hit_data, hit_flag, held_bcid, held_hit,
                    held_flag);
            end
            if (frame_valid && frame_ready) begin
                match_expected();
                accepted_now  = 1'b1;
                accepted_bcid = bcid;
            end
            held_valid = frame_valid && !frame_ready;
            held_bcid  = bcid;
            held_hit   = hit_data;
            held_flag  = hit_flag;
        end else begin
            held_valid = 1'b0;
        end
    endtask

    // outputs are settled 1 ns after the edge and stay until the next one
    task automatic step();
        @(posedge USER_CLK);
        #1;
        drive_inputs();
        observe_output();
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (!locked) begin
            if (n == LOCK_TIMEOUT) begin
                abort_run($sformatf("timeout: locked did not rise within %0d cycles", LOCK_TIMEOUT));
            end
            step();
            n++;
        end
    endtask

    task automatic wait_accepts(input int count);
        int n;
        for (int i = 0; i < count; i++) begin
            n = 0;
            step();
            while (!accepted_now) begin
                if (n == FRAME_TIMEOUT) begin
                    abort_run("timeout: no frame was accepted on the output");
                end
                step();
                n++;
            end
        end
    endtask

    task automatic wait_accept_bcid(input logic [BCID_W-1:0] target);
        int n;
        n = 0;
        step();
        while (!(accepted_now && accepted_bcid == target)) begin
            if (n == FRAME_TIMEOUT) begin
                abort_run($sformatf("timeout: frame with bcid %h never left the output", target));
            end
            step();
            n++;
        end
    endtask

    task automatic wait_corrupt_built();
        int n;
        n = 0;
        while (corrupt_left > 0) begin
            if (n == FRAME_TIMEOUT) begin
                abort_run("timeout: frames with corrupted headers were never sent");
            end
            step();
            n++;
        end
    endtask

    task automatic wait_disconnect(input logic level);
        int n;
        n = 0;
        while (disconnected !== level) begin
            if (n == LINE_TIMEOUT) begin
                abort_run($sformatf("timeout: disconnected did not go to %b", level));
            end
            step();
            n++;
        end
    endtask

    initial begin
        system_reset_r2 = 1'b1;
        line_word       = '0;
        frame_ready     = 1'b0;
        push_filler(START_OFFSET);

        repeat (5) begin
            @(posedge USER_CLK);
            #1;
            check_reset_state();
        end
        system_reset_r2 = 1'b0;
        drive_inputs();  // first stream word starts slot 0
        step();
        check_reset_state();

        // lock at the bit offset of the stream
        wait_lock();
        check_slip(slip_pos, slip_t'(START_OFFSET % FRAME_W));

        // in-order delivery with ready held high
        wait_accepts(24);

        // random back-pressure
        drop_base  = dropped_count;
        skip_base  = skip_total;
        allow_skip = 1'b1;
        ready_mode = 2;
        repeat (600) step();
        ready_mode = 1;
        wait_accepts(3);  // second accept closes the last gap
        allow_skip = 1'b0;
        if (skip_total == skip_base) begin
            abort_run("back-pressure phase dropped no frames");
        end
        check_count("dropped_count increase", dropped_count - drop_base,
            DROP_W'(skip_total - skip_base));

        // 5 bad headers are tolerated, 16 in total drop the lock
        corrupt_left = 5;
        wait_corrupt_built();
        wait_accept_bcid(last_bad_bcid);
        check_status("locked after 5 bad headers", locked, 1'b1);
        corrupt_left = 11;
        wait_corrupt_built();
        wait_accept_bcid(last_bad_bcid);
        check_status("locked after 16 bad headers", locked, 1'b0);
        repeat (48) begin  // relock needs 16 more frames
            step();
            check_status("frame_valid after lock loss", frame_valid, 1'b0);
            check_status("locked after lock loss", locked, 1'b0);
        end

        // stuck line, then live data again
        check_output = 1'b0;
        line_mode    = 1;
        wait_disconnect(1'b1);
        line_mode = 2;
        wait_disconnect(1'b0);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+testbench
src/pad_link_pkg.sv
src/frame_gather.sv
src/frame_aligner.sv
src/link_lock_fsm.sv
src/frame_output.sv
src/pad_link_top.sv
testbench/tb_pad_link.sv

// ==== Makefile ====
TOP := tb_pad_link

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module pad_link_top -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir
